/* tb.f */
logic/cart_pkg.sv
logic/rom_write_port.sv
logic/cart_header_capture.sv
logic/chip_classify.sv
logic/cart_loader.sv
bench/tb_clock.sv
bench/tb_cart_loader.sv

/* bench/tb_cart_loader.sv */
// ====================
// Directed tests for the cart loader with a bench model of the ROM memory
// ====================
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader import cart_pkg::*; ();

	// About 60 writes of at most 10 cycles each
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int ACK_SEED       = 32'h7e41_33ea;

	wire                     clk_sys;
	wire                     RESET_N;
	logic                    ioctl_download;
	logic [INDEX_W-1:0]      ioctl_index;
	logic                    ioctl_wr;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [WORD_W-1:0]       ioctl_dout;
	logic [FILESIZE_W-1:0]   ioctl_filesize;
	logic [MAP_MODE_W-1:0]   map_mode;
	logic                    mem_ack;
	wire                     ioctl_wait;
	wire                     mem_req;
	wire [ROM_ADDR_W-1:1]    mem_addr;
	wire [WORD_W-1:0]        mem_data;
	wire [ROM_TYPE_W-1:0]    rom_type;
	wire [MASK_W-1:0]        rom_mask;
	wire [MASK_W-1:0]        ram_mask;

	int error_count = 0;
	int check_count = 0;
	int req_count   = 0;
	int cycle_count = 0;

	// Memory contents seen by the responder and keyed by word address
	logic [WORD_W-1:0]       mem_model [int unsigned];
	logic [IOCTL_ADDR_W-1:0] sent_addr [$];
	logic [WORD_W-1:0]       sent_data [$];

	tb_clock u_clk (
		.clk_sys (clk_sys),
		.RESET_N (RESET_N)
	);

	cart_loader u_dut (
		.clk_sys        (clk_sys),
		.RESET_N        (RESET_N),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_filesize (ioctl_filesize),
		.ioctl_wait     (ioctl_wait),
		.map_mode       (map_mode),
		.mem_req        (mem_req),
		.mem_ack        (mem_ack),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask)
	);

	// ====================
	// Memory responder
	// ====================
	initial begin : responder
		int ack_delay;
		void'($urandom(ACK_SEED));
		mem_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (mem_req) begin
				ack_delay = $urandom_range(5, 0);
				repeat (ack_delay) begin
					@(posedge clk_sys);
					#2;
				end
				mem_model[mem_addr] = mem_data;
				req_count++;
				mem_ack = 1'b1;
				while (mem_req) begin
					@(posedge clk_sys);
					#2;
				end
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: tests did not complete within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic write_word(input logic [IOCTL_ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] data);
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#2;
		end
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_sys);
		#2;
		ioctl_wr = 1'b0;
		sent_addr.push_back(addr);
		sent_data.push_back(data);
	endtask

	// One download of word zero, some body words and the four header words
	task automatic load_image(input logic [INDEX_W-1:0] index, input logic [1:0] mode,
			input logic [FILESIZE_W-1:0] filesize, input logic [23:0] hdr_base,
			input int body_words, input logic [7:0] mapper, input logic [7:0] cart_type,
			input logic [3:0] rom_code, input logic [3:0] ram_code, input logic [7:0] maker);
		logic [IOCTL_ADDR_W-1:0] skip;
		logic [IOCTL_ADDR_W-1:0] addr;
		int i;
		skip = IOCTL_ADDR_W'(filesize[9:0]);
		sent_addr.delete();
		sent_data.delete();
		map_mode       = mode;
		ioctl_index    = index;
		ioctl_filesize = filesize;
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#2;
		write_word(skip, 16'h7801);
		for (i = 1; i <= body_words; i++) begin
			addr = skip + IOCTL_ADDR_W'(2 * i);
			write_word(addr, addr[15:0] ^ 16'(addr[IOCTL_ADDR_W-1:16]) ^ 16'hC3A5);
		end
		write_word(skip + hdr_base, {mapper, 8'h20});
		write_word(skip + hdr_base + 2, {4'h0, rom_code, cart_type});
		write_word(skip + hdr_base + 4, {8'h01, 4'h0, ram_code});
		write_word(skip + hdr_base + 6, {8'h00, maker});
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#2;
		end
		ioctl_download = 1'b0;
		repeat (3) @(posedge clk_sys);
		#2;
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic check_reset_state;
		check_value("mem_req after reset", mem_req, 0);
		check_value("ioctl_wait after reset", ioctl_wait, 0);
		check_value("rom_type after reset", rom_type, 0);
		check_value("rom_mask after reset", rom_mask, 0);
		check_value("ram_mask after reset", ram_mask, 0);
	endtask

	task automatic classify_lorom_dsp1;
		load_image(8'h00, 2'd0, 24'h100000, 24'h007FD4, 4, 8'h20, 8'h03, 4'hA, 4'h3, 8'h01);
		check_value("DSP1 rom_type", rom_type, 32'h80);
		check_value("DSP1 rom_mask", rom_mask, 32'h0F_FFFF);
		check_value("DSP1 ram_mask", ram_mask, 32'd8191);
	endtask

	task automatic strip_copier_header;
		int base_reqs;
		int unsigned word_addr;
		mem_model.delete();
		base_reqs = req_count;
		load_image(8'h01, 2'd1, 24'h200200, 24'h00FFD4, 12, 8'h23, 8'h35, 4'hB, 4'h2, 8'h33);
		check_value("memory write count", req_count - base_reqs, sent_addr.size());
		foreach (sent_addr[k]) begin
			word_addr = (sent_addr[k] - 512) >> 1;
			check_value("write recorded at word address", mem_model.exists(word_addr), 1);
			if (mem_model.exists(word_addr)) begin
				check_value("written data", mem_model[word_addr], sent_data[k]);
			end
		end
		check_value("SA1 rom_type", rom_type, 32'h61);
		check_value("SA1 rom_mask", rom_mask, 32'h1F_FFFF);
		check_value("SA1 ram_mask", ram_mask, 32'h0FFF);
	endtask

	task automatic classify_gsu_spc7110;
		// ROM code 5 is below the minimum and counts as 12
		load_image(8'h00, 2'd0, 24'h100000, 24'h007FD4, 4, 8'h20, 8'h15, 4'h5, 4'h0, 8'h01);
		check_value("GSU rom_type", rom_type, 32'h70);
		check_value("GSU rom_mask", rom_mask, 32'h3F_FFFF);
		check_value("GSU ram_mask", ram_mask, 32'd65535);
		load_image(8'h01, 2'd2, 24'h600000, 24'h40FFD4, 4, 8'h3A, 8'hF9, 4'hD, 4'h5, 8'h33);
		check_value("SPC7110 rom_type", rom_type, 32'hDA);
		check_value("SPC7110 rom_mask", rom_mask, 32'h7F_FFFF);
		check_value("SPC7110 ram_mask", ram_mask, 32'h7FFF);
	endtask

	task automatic ignore_other_index;
		int base_reqs;
		base_reqs = req_count;
		load_image(8'h02, 2'd0, 24'h080000, 24'h007FD4, 4, 8'h20, 8'hF3, 4'h9, 4'h1, 8'h01);
		check_value("requests for index 2", req_count - base_reqs, 0);
		check_value("mem_req for index 2", mem_req, 0);
		check_value("rom_type kept", rom_type, 32'hDA);
		check_value("rom_mask kept", rom_mask, 32'h7F_FFFF);
		check_value("ram_mask kept", ram_mask, 32'h7FFF);
	endtask

	initial begin : main_seq
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_filesize = '0;
		map_mode       = '0;
		wait (RESET_N === 1'b1);
		@(posedge clk_sys);
		#2;
		check_reset_state();
		classify_lorom_dsp1();
		strip_copier_header();
		classify_gsu_spc7110();
		ignore_other_index();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// ====================
// Bench clock and synchronous reset for the cart loader testbench
// ====================
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic RESET_N
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk_sys = 1'b0;
		forever begin
			#HALF_PERIOD clk_sys = ~clk_sys;
		end
	end

	// Reset low over the first two rising edges
	initial begin
		RESET_N = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2;
		RESET_N = 1'b1;
	end

endmodule

`default_nettype wire

/* logic/cart_loader.sv */
// ====================
// Cart loading path top, download stream in and ROM writes plus cart info out
// ====================
`timescale 1ns/100ps
`default_nettype none

module cart_loader import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire                    ioctl_download,
	input  wire [INDEX_W-1:0]      ioctl_index,
	input  wire                    ioctl_wr,
	input  wire [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  wire [WORD_W-1:0]       ioctl_dout,
	input  wire [FILESIZE_W-1:0]   ioctl_filesize,
	output wire                    ioctl_wait,
	input  wire [MAP_MODE_W-1:0]   map_mode,
	output wire                    mem_req,
	input  wire                    mem_ack,
	output wire [ROM_ADDR_W-1:1]   mem_addr,
	output wire [WORD_W-1:0]       mem_data,
	output wire [ROM_TYPE_W-1:0]   rom_type,
	output wire [MASK_W-1:0]       rom_mask,
	output wire [MASK_W-1:0]       ram_mask
);

	// Write stream seen by the header capture
	wire                   hdr_wr;
	wire [ROM_ADDR_W-1:0]  hdr_addr;
	wire [WORD_W-1:0]      hdr_data;
	wire                   cart_active;

	// Parsed header fields
	wire [7:0]             mapper_byte;
	wire [ROM_TYPE_W-1:0]  type_byte;
	wire [7:0]             maker_byte;
	wire [SIZE_CODE_W-1:0] rom_size_code;
	wire [SIZE_CODE_W-1:0] ram_size_code;
	wire [MAP_MODE_W-1:0]  map_mode_latched;

	rom_write_port u_port (
		.clk_sys        (clk_sys),
		.RESET_N        (RESET_N),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_filesize (ioctl_filesize),
		.ioctl_wait     (ioctl_wait),
		.mem_req        (mem_req),
		.mem_ack        (mem_ack),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.hdr_wr         (hdr_wr),
		.hdr_addr       (hdr_addr),
		.hdr_data       (hdr_data),
		.cart_active    (cart_active)
	);

	cart_header_capture u_hdr (
		.clk_sys          (clk_sys),
		.RESET_N          (RESET_N),
		.hdr_wr           (hdr_wr),
		.hdr_addr         (hdr_addr),
		.hdr_data         (hdr_data),
		.map_mode         (map_mode),
		.mapper_byte      (mapper_byte),
		.type_byte        (type_byte),
		.maker_byte       (maker_byte),
		.rom_size_code    (rom_size_code),
		.ram_size_code    (ram_size_code),
		.map_mode_latched (map_mode_latched)
	);

	chip_classify u_cls (
		.clk_sys          (clk_sys),
		.RESET_N          (RESET_N),
		.cart_active      (cart_active),
		.mapper_byte      (mapper_byte),
		.type_byte        (type_byte),
		.maker_byte       (maker_byte),
		.rom_size_code    (rom_size_code),
		.ram_size_code    (ram_size_code),
		.map_mode_latched (map_mode_latched),
		.rom_type         (rom_type),
		.rom_mask         (rom_mask),
		.ram_mask         (ram_mask)
	);

endmodule

`default_nettype wire

/* logic/chip_classify.sv */
// ====================
// Derives coprocessor type and ROM/RAM masks from the captured header
// ====================
`timescale 1ns/100ps
`default_nettype none

module chip_classify import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire                    cart_active,
	input  wire [7:0]              mapper_byte,
	input  wire [ROM_TYPE_W-1:0]   type_byte,
	input  wire [7:0]              maker_byte,
	input  wire [SIZE_CODE_W-1:0]  rom_size_code,
	input  wire [SIZE_CODE_W-1:0]  ram_size_code,
	input  wire [MAP_MODE_W-1:0]   map_mode_latched,
	output logic [ROM_TYPE_W-1:0]  rom_type,
	output logic [MASK_W-1:0]      rom_mask,
	output logic [MASK_W-1:0]      ram_mask
);

	logic [CHIP_W-1:0]      chip_c;
	logic                   bit3_c;
	logic [SIZE_CODE_W-1:0] ram_code_c;
	logic [SIZE_CODE_W-1:0] rom_code_c;
	logic                   loaded;

	// ====================
	// Coprocessor priority decode
	// ====================
	always_comb begin
		chip_c     = CHIP_NONE;
		bit3_c     = 1'b0;
		ram_code_c = ram_size_code;
		if (mapper_byte == 8'h30 && type_byte == 8'h05 && maker_byte == 8'hB2) begin
			chip_c = CHIP_DSP3;
		end else if (((mapper_byte == 8'h20 || mapper_byte == 8'h21) && type_byte == 8'h03) ||
				(mapper_byte == 8'h30 && type_byte == 8'h05) ||
				(mapper_byte == 8'h31 && (type_byte == 8'h03 || type_byte == 8'h05))) begin
			chip_c = CHIP_DSP1;
		end else if (mapper_byte == 8'h20 && type_byte == 8'h05) begin
			chip_c = CHIP_DSP2;
		end else if (mapper_byte == 8'h30 && type_byte == 8'h03) begin
			chip_c = CHIP_DSP4;
		end else if (mapper_byte == 8'h30 && type_byte == 8'h25) begin
			chip_c = CHIP_OBC1;
		end else if (mapper_byte == 8'h32 && (type_byte == 8'h43 || type_byte == 8'h45)) begin
			chip_c = CHIP_SDD1;
		end else if (mapper_byte == 8'h30 && type_byte == 8'hF6) begin
			// ST0xx, small ROMs get bit 5 as well
			chip_c = CHIP_DSP1 | ((rom_size_code < ST_SMALL_ROM_CODE) ? 4'h2 : 4'h0);
			bit3_c = 1'b1;
		end else if (mapper_byte == 8'h20 && (type_byte == 8'h13 || type_byte == 8'h14 ||
				type_byte == 8'h15 || type_byte == 8'h1A)) begin
			chip_c     = CHIP_GSU;
			ram_code_c = GSU_RAM_SIZE_CODE;
		end else if (mapper_byte == 8'h23 && (type_byte == 8'h32 || type_byte == 8'h34 ||
				type_byte == 8'h35)) begin
			chip_c = CHIP_SA1;
		end else if (mapper_byte == 8'h3A && (type_byte == 8'hF5 || type_byte == 8'hF9)) begin
			// Bit 3 marks the RTC variant
			chip_c = CHIP_SPC7110;
			bit3_c = type_byte[3];
		end else if (mapper_byte == 8'h20 && type_byte == 8'hF3) begin
			chip_c = CHIP_CX4;
		end
	end

	assign rom_code_c = (rom_size_code < MIN_ROM_SIZE_CODE) ? DEFAULT_ROM_SIZE_CODE :
		rom_size_code;

	// Results track the header between downloads, once a cart was seen
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			loaded   <= 1'b0;
			rom_type <= '0;
			rom_mask <= '0;
			ram_mask <= '0;
		end else if (cart_active) begin
			loaded <= 1'b1;
		end else if (loaded) begin
			rom_type <= {chip_c, bit3_c, 1'b0, map_mode_latched};
			rom_mask <= (MASK_UNIT << rom_code_c) - 1'b1;
			ram_mask <= (ram_code_c == '0) ? '0 : (MASK_UNIT << ram_code_c) - 1'b1;
		end
	end

	a_type_stable: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		(cart_active && $past(cart_active)) |-> $stable(rom_type));

endmodule

`default_nettype wire

/* logic/cart_header_capture.sv */
// ====================
// Picks the internal header bytes out of the cart write stream
// ====================
`timescale 1ns/100ps
`default_nettype none

module cart_header_capture import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire                    hdr_wr,
	input  wire [ROM_ADDR_W-1:0]   hdr_addr,
	input  wire [WORD_W-1:0]       hdr_data,
	input  wire [MAP_MODE_W-1:0]   map_mode,
	output logic [7:0]             mapper_byte,
	output logic [ROM_TYPE_W-1:0]  type_byte,
	output logic [7:0]             maker_byte,
	output logic [SIZE_CODE_W-1:0] rom_size_code,
	output logic [SIZE_CODE_W-1:0] ram_size_code,
	output logic [MAP_MODE_W-1:0]  map_mode_latched
);

	logic [8:0] hdr_prefix;
	logic       hit_mapper;
	logic       hit_type;
	logic       hit_ram;
	logic       hit_maker;

	// Bank that holds the header for the current map mode
	always_comb begin
		case (map_mode_latched)
		2'd1:    hdr_prefix = HDR_PREFIX_HI;
		2'd2:    hdr_prefix = HDR_PREFIX_EXHI;
		default: hdr_prefix = HDR_PREFIX_LO;
		endcase
	end

	assign hit_mapper = (hdr_addr == {hdr_prefix, HDR_OFS_MAPPER});
	assign hit_type   = (hdr_addr == {hdr_prefix, HDR_OFS_TYPE});
	assign hit_ram    = (hdr_addr == {hdr_prefix, HDR_OFS_RAM});
	assign hit_maker  = (hdr_addr == {hdr_prefix, HDR_OFS_MAKER});

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			mapper_byte      <= '0;
			type_byte        <= '0;
			maker_byte       <= '0;
			rom_size_code    <= '0;
			ram_size_code    <= '0;
			map_mode_latched <= '0;
		end else if (hdr_wr) begin
			// First ROM word starts a new image
			if (hdr_addr == '0) begin
				ram_size_code    <= '0;
				map_mode_latched <= map_mode;
			end
			if (hit_mapper) begin
				mapper_byte <= hdr_data[15:8];
			end
			// Cart type below, ROM size code in the upper byte
			if (hit_type) begin
				type_byte     <= hdr_data[7:0];
				rom_size_code <= hdr_data[11:8];
			end
			if (hit_ram) begin
				ram_size_code <= hdr_data[3:0];
			end
			if (hit_maker) begin
				maker_byte <= hdr_data[7:0];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/rom_write_port.sv */
// ====================
// Turns cart download words into ROM writes over a four-phase req/ack port
// ====================
`timescale 1ns/100ps
`default_nettype none

module rom_write_port import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire                    ioctl_download,
	input  wire [INDEX_W-1:0]      ioctl_index,
	input  wire                    ioctl_wr,
	input  wire [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  wire [WORD_W-1:0]       ioctl_dout,
	input  wire [FILESIZE_W-1:0]   ioctl_filesize,
	output logic                   ioctl_wait,
	output logic                   mem_req,
	input  wire                    mem_ack,
	output wire [ROM_ADDR_W-1:1]   mem_addr,
	output wire [WORD_W-1:0]       mem_data,
	output logic                   hdr_wr,
	output wire [ROM_ADDR_W-1:0]   hdr_addr,
	output wire [WORD_W-1:0]       hdr_data,
	output logic                   cart_active
);

	logic                    cart_sel;
	logic                    wr_accept;
	logic [IOCTL_ADDR_W-1:0] addr_adj;
	logic [1:0]              state;
	logic [ROM_ADDR_W-1:0]   addr_q;
	logic [WORD_W-1:0]       data_q;

	assign cart_sel = ioctl_download && (ioctl_index[5:1] == CART_INDEX_SEL[5:1]);

	// Copier header length is the file size modulo 1024
	assign addr_adj  = ioctl_addr - IOCTL_ADDR_W'(ioctl_filesize[SMC_HDR_BITS-1:0]);
	assign wr_accept = cart_sel && ioctl_wr && (state == WR_IDLE);

	// Write payload, held for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			addr_q <= addr_adj[ROM_ADDR_W-1:0];
			data_q <= ioctl_dout;
		end
	end

	assign mem_addr = addr_q[ROM_ADDR_W-1:1];
	assign mem_data = data_q;
	assign hdr_addr = addr_q;
	assign hdr_data = data_q;

	// ====================
	// Four-phase request FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			state       <= WR_IDLE;
			mem_req     <= 1'b0;
			ioctl_wait  <= 1'b0;
			hdr_wr      <= 1'b0;
			cart_active <= 1'b0;
		end else begin
			cart_active <= cart_sel;
			hdr_wr      <= wr_accept;
			case (state)
			WR_IDLE: begin
				if (wr_accept) begin
					state      <= WR_REQ;
					mem_req    <= 1'b1;
					ioctl_wait <= 1'b1;
				end
			end
			WR_REQ: begin
				if (mem_ack) begin
					state   <= WR_REL;
					mem_req <= 1'b0;
				end
			end
			WR_REL: begin
				// Wait for the responder to let go of ack
				if (!mem_ack) begin
					state      <= WR_IDLE;
					ioctl_wait <= 1'b0;
				end
			end
			default: begin
				state      <= WR_IDLE;
				mem_req    <= 1'b0;
				ioctl_wait <= 1'b0;
			end
			endcase
		end
	end

	// Request is only withdrawn after the responder acknowledged it
	a_req_hold: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		$fell(mem_req) |-> $past(mem_ack));

	// Download source honours back-pressure
	a_wr_wait: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		ioctl_wr |-> !ioctl_wait);

endmodule

`default_nettype wire

/* logic/cart_pkg.sv */
// ====================
// Shared widths, header offsets and coprocessor codes for the cart loader
// ====================
`default_nettype none

package cart_pkg;

	// ====================
	// Widths
	// ====================
	localparam int IOCTL_ADDR_W = 25;
	localparam int ROM_ADDR_W   = 24;
	localparam int WORD_W       = 16;
	localparam int MASK_W       = 24;
	localparam int ROM_TYPE_W   = 8;
	localparam int INDEX_W      = 8;
	localparam int FILESIZE_W   = 24;
	localparam int MAP_MODE_W   = 2;
	localparam int SIZE_CODE_W  = 4;
	localparam int CHIP_W       = 4;

	// ====================
	// Download and header locations
	// ====================
	// Index bits 5:1 at zero select a cart image
	localparam logic [5:0]  CART_INDEX_SEL  = 6'h00;
	localparam int          SMC_HDR_BITS    = 10;
	localparam logic [14:0] HDR_OFS_MAPPER  = 15'h7FD4;
	localparam logic [14:0] HDR_OFS_TYPE    = 15'h7FD6;
	localparam logic [14:0] HDR_OFS_RAM     = 15'h7FD8;
	localparam logic [14:0] HDR_OFS_MAKER   = 15'h7FDA;
	localparam logic [8:0]  HDR_PREFIX_LO   = 9'h000;
	localparam logic [8:0]  HDR_PREFIX_HI   = 9'h001;
	localparam logic [8:0]  HDR_PREFIX_EXHI = 9'h081;

	// Write port FSM
	localparam logic [1:0] WR_IDLE = 2'd0;
	localparam logic [1:0] WR_REQ  = 2'd1;
	localparam logic [1:0] WR_REL  = 2'd2;

	// ====================
	// Classification
	// ====================
	localparam logic [CHIP_W-1:0] CHIP_NONE    = 4'h0;
	localparam logic [CHIP_W-1:0] CHIP_CX4     = 4'h4;
	localparam logic [CHIP_W-1:0] CHIP_SDD1    = 4'h5;
	localparam logic [CHIP_W-1:0] CHIP_SA1     = 4'h6;
	localparam logic [CHIP_W-1:0] CHIP_GSU     = 4'h7;
	localparam logic [CHIP_W-1:0] CHIP_DSP1    = 4'h8;
	localparam logic [CHIP_W-1:0] CHIP_DSP2    = 4'h9;
	localparam logic [CHIP_W-1:0] CHIP_DSP3    = 4'hA;
	localparam logic [CHIP_W-1:0] CHIP_DSP4    = 4'hB;
	localparam logic [CHIP_W-1:0] CHIP_OBC1    = 4'hC;
	localparam logic [CHIP_W-1:0] CHIP_SPC7110 = 4'hD;

	localparam logic [SIZE_CODE_W-1:0] MIN_ROM_SIZE_CODE     = 4'd7;
	localparam logic [SIZE_CODE_W-1:0] DEFAULT_ROM_SIZE_CODE = 4'd12;
	localparam logic [SIZE_CODE_W-1:0] ST_SMALL_ROM_CODE     = 4'd10;
	localparam logic [SIZE_CODE_W-1:0] GSU_RAM_SIZE_CODE     = 4'd6;
	localparam logic [MASK_W-1:0]      MASK_UNIT             = 24'd1024;

endpackage

`default_nettype wire
